// File: rtl/cpuCore.sv
`timescale 1ns/1ps

module cpuCore import isaPkg::*, pipePkg::*; #(
	parameter word resetVector = 32'h0000_0000
) (
	input  logic     clk,
	input  logic     reset,
	output word      instrAddr,
	input  instrWord instrData,
	output word      dataAddr,
	output word      dataWdata,
	output logic     dataWe,
	input  word      dataRdata,
	output logic     wbValid,
	output regAddr   wbRd,
	output word      wbData
);

	hazardCtrl ctrl;
	fetchDecodeReg fd;
	decodeExecReg de;
	execMemReg em;
	memWbReg mw;
	logic redirect;
	word redirectPc;

	fetchStage #(
		.resetVector(resetVector)
	) fetch (
		.clk       (clk),
		.reset     (reset),
		.ctrl      (ctrl),
		.redirect  (redirect),
		.redirectPc(redirectPc),
		.instrAddr (instrAddr),
		.instrData (instrData),
		.fdOut     (fd)
	);

	decodeStage decode (
		.clk  (clk),
		.reset(reset),
		.ctrl (ctrl),
		.fdIn (fd),
		.wb   (mw),
		.deOut(de)
	);

	executeStage execute (
		.clk       (clk),
		.reset     (reset),
		.ctrl      (ctrl),
		.deIn      (de),
		.memFwd    (em.result),
		.wbFwd     (mw.result),
		.emOut     (em),
		.redirect  (redirect),
		.redirectPc(redirectPc)
	);

	memoryStage memory (
		.clk      (clk),
		.reset    (reset),
		.emIn     (em),
		.dataAddr (dataAddr),
		.dataWdata(dataWdata),
		.dataWe   (dataWe),
		.dataRdata(dataRdata),
		.mwOut    (mw)
	);

	hazardUnit hazard (
		.de      (de),
		.fd      (fd),
		.em      (em),
		.mw      (mw),
		.redirect(redirect),
		.ctrl    (ctrl)
	);

	// Mirror of the register file write port.
	assign wbValid = mw.valid && mw.regWe && (mw.rd != '0);
	assign wbRd = mw.rd;
	assign wbData = mw.result;

endmodule

// File: rtl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import isaPkg::*, pipePkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  hazardCtrl     ctrl,
	input  fetchDecodeReg fdIn,
	input  memWbReg       wb,
	output decodeExecReg  deOut
);

	instrWord instr;
	logic [6:0] opcode;
	logic [2:0] funct3;
	regAddr rs1;
	regAddr rs2;
	regAddr rd;
	word rdata1;
	word rdata2;
	word immI;
	word immS;
	word immB;
	word immJ;
	decodeExecReg next;

	assign instr = fdIn.instr;
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	regFile regs (
		.clk   (clk),
		.reset (reset),
		.rs1   (rs1),
		.rs2   (rs2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.wb    (wb)
	);

	always_comb begin
		next = '0;
		next.valid = fdIn.valid;
		next.pc = fdIn.pc;
		next.rs1 = rs1;
		next.rs2 = rs2;
		next.rd = rd;
		next.rdata1 = rdata1;
		next.rdata2 = rdata2;
		next.opCls = opOther;
		next.alu = aluAdd;
		next.branch = brNone;
		if (fdIn.valid) begin
			case (opcode)
				opcodeOp: begin
					next.regWe = 1'b1;
					case (funct3)
						3'b000: next.alu = instr[30] ? aluSub : aluAdd;
						3'b010: next.alu = aluSlt;
						3'b100: next.alu = aluXor;
						3'b110: next.alu = aluOr;
						3'b111: next.alu = aluAnd;
						default: next.regWe = 1'b0;
					endcase
				end
				opcodeOpImm: begin
					// Only ADDI is implemented.
					next.regWe = (funct3 == 3'b000);
					next.useImm = 1'b1;
					next.imm = immI;
				end
				opcodeLoad: begin
					if (funct3 == 3'b010) begin
						next.opCls = opLoad;
						next.regWe = 1'b1;
					end
					next.useImm = 1'b1;
					next.imm = immI;
				end
				opcodeStore: begin
					if (funct3 == 3'b010) begin
						next.opCls = opStore;
					end
					next.useImm = 1'b1;
					next.imm = immS;
				end
				opcodeBranch: begin
					case (funct3)
						3'b000: next.branch = brEq;
						3'b001: next.branch = brNe;
						default: next.branch = brNone;
					endcase
					next.imm = immB;
				end
				opcodeJal: begin
					next.opCls = opJump;
					next.branch = brJal;
					next.regWe = 1'b1;
					next.imm = immJ;
				end
				default: begin
					next.regWe = 1'b0;
				end
			endcase
		end
		// Writes to x0 are dropped here, once for the whole pipe.
		if (rd == '0) begin
			next.regWe = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		deOut <= next;
		if (reset || ctrl.flushExec) begin
			deOut.valid <= 1'b0;
		end
	end

endmodule

// File: rtl/executeStage.sv
`timescale 1ns/1ps

module executeStage import isaPkg::*, pipePkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  hazardCtrl    ctrl,
	input  decodeExecReg deIn,
	input  word          memFwd,
	input  word          wbFwd,
	output execMemReg    emOut,
	output logic         redirect,
	output word          redirectPc
);

	word opA;
	word opB;
	word srcB;
	word aluResult;
	logic taken;
	execMemReg next;

	function automatic word pickOperand(fwdSel sel, word regVal, word memVal, word wbVal);
		case (sel)
			fwdMem: return memVal;
			fwdWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign opA = pickOperand(ctrl.fwdA, deIn.rdata1, memFwd, wbFwd);
	assign opB = pickOperand(ctrl.fwdB, deIn.rdata2, memFwd, wbFwd);
	assign srcB = deIn.useImm ? deIn.imm : opB;

	always_comb begin
		case (deIn.alu)
			aluSub: aluResult = opA - srcB;
			aluAnd: aluResult = opA & srcB;
			aluOr: aluResult = opA | srcB;
			aluXor: aluResult = opA ^ srcB;
			aluSlt: aluResult = {31'd0, $signed(opA) < $signed(srcB)};
			default: aluResult = opA + srcB;
		endcase
	end

	// Branch compare uses both register operands.
	always_comb begin
		case (deIn.branch)
			brEq: taken = (opA == opB);
			brNe: taken = (opA != opB);
			brJal: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign redirect = deIn.valid && taken;
	assign redirectPc = deIn.pc + deIn.imm;

	always_comb begin
		next.valid = deIn.valid;
		next.opCls = deIn.opCls;
		next.rd = deIn.rd;
		next.regWe = deIn.regWe;
		next.result = (deIn.branch == brJal) ? deIn.pc + 32'd4 : aluResult;
		next.storeData = opB;
	end

	always_ff @(posedge clk) begin
		emOut <= next;
		if (reset) begin
			emOut.valid <= 1'b0;
		end
	end

endmodule

// File: rtl/fetchStage.sv
`timescale 1ns/1ps

module fetchStage import isaPkg::*, pipePkg::*; #(
	parameter word resetVector = 32'h0000_0000
) (
	input  logic          clk,
	input  logic          reset,
	input  hazardCtrl     ctrl,
	input  logic          redirect,
	input  word           redirectPc,
	output word           instrAddr,
	input  instrWord      instrData,
	output fetchDecodeReg fdOut
);

	word pc;

	assign instrAddr = pc;

	// A redirect never coincides with a load-use stall.
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetVector;
		end else if (redirect) begin
			pc <= redirectPc;
		end else if (!ctrl.stallFetch) begin
			pc <= pc + 32'd4;
		end
	end

	// Flush wins over stall.
	always_ff @(posedge clk) begin
		if (reset || ctrl.flushDecode) begin
			fdOut.valid <= 1'b0;
		end else if (!ctrl.stallDecode) begin
			fdOut.valid <= 1'b1;
		end
		if (!ctrl.stallDecode) begin
			fdOut.pc <= pc;
			fdOut.instr <= instrData;
		end
	end

endmodule

// File: rtl/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit import isaPkg::*, pipePkg::*; (
	input  decodeExecReg  de,
	input  fetchDecodeReg fd,
	input  execMemReg     em,
	input  memWbReg       mw,
	input  logic          redirect,
	output hazardCtrl     ctrl
);

	regAddr rs1D;
	regAddr rs2D;
	logic loadUse;

	// Memory stage is younger, so it is checked first.
	function automatic fwdSel pickSource(regAddr src, execMemReg memReg, memWbReg wbReg);
		if (src == '0) begin
			return fwdReg;
		end
		if (memReg.valid && memReg.regWe && memReg.rd == src) begin
			return fwdMem;
		end
		if (wbReg.valid && wbReg.regWe && wbReg.rd == src) begin
			return fwdWb;
		end
		return fwdReg;
	endfunction

	// Decode sources come straight from the raw instruction.
	assign rs1D = fd.instr[19:15];
	assign rs2D = fd.instr[24:20];

	assign loadUse = de.valid && (de.opCls == opLoad) && (de.rd != '0) && fd.valid &&
		((de.rd == rs1D) || (de.rd == rs2D));

	always_comb begin
		ctrl.fwdA = pickSource(de.rs1, em, mw);
		ctrl.fwdB = pickSource(de.rs2, em, mw);

		// Load-use holds fetch and decode and drops a bubble into execute.
		ctrl.stallFetch = loadUse;
		ctrl.stallDecode = loadUse;

		// Taken branch or jump kills the two younger instructions.
		ctrl.flushDecode = redirect;
		ctrl.flushExec = redirect || loadUse;
	end

endmodule

// File: rtl/isaPkg.sv
package isaPkg;

	// Data, address and instruction widths.
	typedef logic [31:0] word;
	typedef logic [4:0] regAddr;
	typedef logic [31:0] instrWord;

	// Command classes seen by decode, execute and the hazard unit.
	typedef enum logic [1:0] {
		opOther = 2'b00,
		opJump  = 2'b01,
		opStore = 2'b10,
		opLoad  = 2'b11
	} opClass;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt
	} aluOp;

	typedef enum logic [1:0] {
		brNone,
		brEq,
		brNe,
		brJal
	} branchKind;

	// Major opcodes of the supported subset.
	localparam logic [6:0] opcodeOp     = 7'b0110011;
	localparam logic [6:0] opcodeOpImm  = 7'b0010011;
	localparam logic [6:0] opcodeLoad   = 7'b0000011;
	localparam logic [6:0] opcodeStore  = 7'b0100011;
	localparam logic [6:0] opcodeBranch = 7'b1100011;
	localparam logic [6:0] opcodeJal    = 7'b1101111;

endpackage

// File: rtl/memoryStage.sv
`timescale 1ns/1ps

module memoryStage import isaPkg::*, pipePkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  execMemReg emIn,
	output word       dataAddr,
	output word       dataWdata,
	output logic      dataWe,
	input  word       dataRdata,
	output memWbReg   mwOut
);

	memWbReg next;

	// The ALU result is the address for loads and stores.
	assign dataAddr = emIn.result;
	assign dataWdata = emIn.storeData;
	assign dataWe = emIn.valid && (emIn.opCls == opStore);

	always_comb begin
		next.valid = emIn.valid;
		next.rd = emIn.rd;
		next.regWe = emIn.regWe;
		next.result = (emIn.opCls == opLoad) ? dataRdata : emIn.result;
	end

	always_ff @(posedge clk) begin
		mwOut <= next;
		if (reset) begin
			mwOut.valid <= 1'b0;
		end
	end

endmodule

// File: rtl/pipePkg.sv
package pipePkg;
	import isaPkg::*;

	typedef struct packed {
		logic     valid;
		word      pc;
		instrWord instr;
	} fetchDecodeReg;

	typedef struct packed {
		logic      valid;
		word       pc;
		opClass    opCls;
		aluOp      alu;
		branchKind branch;
		regAddr    rs1;
		regAddr    rs2;
		regAddr    rd;
		logic      regWe;
		logic      useImm;
		word       imm;
		word       rdata1;
		word       rdata2;
	} decodeExecReg;

	typedef struct packed {
		logic   valid;
		opClass opCls;
		regAddr rd;
		logic   regWe;
		word    result;
		word    storeData;
	} execMemReg;

	typedef struct packed {
		logic   valid;
		regAddr rd;
		logic   regWe;
		word    result;
	} memWbReg;

	// Where an execute operand comes from.
	typedef enum logic [1:0] {
		fwdReg,
		fwdMem,
		fwdWb
	} fwdSel;

	typedef struct packed {
		logic  stallFetch;
		logic  stallDecode;
		logic  flushDecode;
		logic  flushExec;
		fwdSel fwdA;
		fwdSel fwdB;
	} hazardCtrl;

endpackage

// File: rtl/regFile.sv
`timescale 1ns/1ps

module regFile import isaPkg::*, pipePkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  regAddr  rs1,
	input  regAddr  rs2,
	output word     rdata1,
	output word     rdata2,
	input  memWbReg wb
);

	word regs [1:31];
	logic wrEn;

	assign wrEn = wb.valid && wb.regWe && (wb.rd != '0);

	// Architectural state starts at zero.
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wb.rd] <= wb.result;
		end
	end

	// Same-cycle write is returned to the reader.
	assign rdata1 = (rs1 == '0) ? '0 : (wrEn && wb.rd == rs1) ? wb.result : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : (wrEn && wb.rd == rs2) ? wb.result : regs[rs2];

endmodule

// File: run.sh
#!/bin/sh
# Build the core with its testbench in Verilator, run it, and judge the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cpuCoreTb -f vlog.f -o simCpuCore
./obj_dir/simCpuCore > sim.log 2>&1
cat sim.log

if grep -qx "Verification passed" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

// File: testbench/tbIsaModel.svh
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// In-order reference for the program in imem.
// Fills wbQ with register writebacks and stQ with stores, in program order.
task automatic runModel(int maxSteps);
	word regs [32];
	word mem [256];
	word pc;
	word nextPc;
	word addr;
	word res;
	word a;
	word b;
	word immI;
	word immS;
	word immB;
	word immJ;
	instrWord ins;
	logic wr;
	wbEvent ev;
	storeEvent st;
	for (int i = 0; i < 32; i++) begin
		regs[i] = '0;
	end
	for (int i = 0; i < 256; i++) begin
		mem[i] = fillWord(i);
	end
	pc = resetVec;
	for (int step = 0; step < maxSteps; step++) begin
		ins = imem[pc[9:2]];
		// The jump to itself marks the end of the program.
		if (ins == jTypeInstr(21'd0, 5'd0)) begin
			break;
		end
		a = regs[ins[19:15]];
		b = regs[ins[24:20]];
		immI = {{20{ins[31]}}, ins[31:20]};
		immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		nextPc = pc + 32'd4;
		wr = 1'b0;
		res = '0;
		case (ins[6:0])
			opcodeOp: begin
				wr = 1'b1;
				case (ins[14:12])
					3'b000: res = ins[30] ? a - b : a + b;
					3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					3'b100: res = a ^ b;
					3'b110: res = a | b;
					3'b111: res = a & b;
					default: wr = 1'b0;
				endcase
			end
			opcodeOpImm: begin
				wr = (ins[14:12] == 3'b000);
				res = a + immI;
			end
			opcodeLoad: begin
				addr = a + immI;
				wr = (ins[14:12] == 3'b010);
				res = mem[addr[9:2]];
			end
			opcodeStore: begin
				if (ins[14:12] == 3'b010) begin
					st.addr = a + immS;
					st.data = b;
					mem[st.addr[9:2]] = b;
					stQ.push_back(st);
				end
			end
			opcodeBranch: begin
				if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
					nextPc = pc + immB;
				end
			end
			opcodeJal: begin
				wr = 1'b1;
				res = pc + 32'd4;
				nextPc = pc + immJ;
			end
			default: begin
			end
		endcase
		// x0 stays zero and never shows up as a writeback.
		if (wr && ins[11:7] != 5'd0) begin
			regs[ins[11:7]] = res;
			ev.rd = ins[11:7];
			ev.data = res;
			wbQ.push_back(ev);
		end
		pc = nextPc;
	end
endtask

`endif

// File: testbench/cpuCoreTb.sv
`timescale 1ns/1ps

module cpuCoreTb import isaPkg::*; ();

	localparam word resetVec = 32'h0000_0000;
	localparam int numPrograms = 6;
	localparam int maxProgLen = 80;
	// Each program gets 4 cycles per instruction, its reset and its drain.
	localparam int limitCycles = numPrograms * (4 * maxProgLen + 8 + 12) + 200;
	localparam logic [2:0] aluFunct3 [6] = '{3'b000, 3'b000, 3'b010, 3'b100, 3'b110, 3'b111};

	typedef struct packed {
		regAddr rd;
		word    data;
	} wbEvent;

	typedef struct packed {
		word addr;
		word data;
	} storeEvent;

	logic clk = 1'b0;
	logic reset;
	word instrAddr;
	instrWord instrData;
	word dataAddr;
	word dataWdata;
	logic dataWe;
	word dataRdata;
	logic wbValid;
	regAddr wbRd;
	word wbData;

	instrWord imem [256];
	word dmem [256];
	wbEvent wbQ [$];
	storeEvent stQ [$];
	string testName;
	int errorsWb = 0;
	int errorsStore = 0;
	int errorsOther = 0;

	always #4 clk = ~clk;

	cpuCore #(
		.resetVector(resetVec)
	) uut (
		.clk      (clk),
		.reset    (reset),
		.instrAddr(instrAddr),
		.instrData(instrData),
		.dataAddr (dataAddr),
		.dataWdata(dataWdata),
		.dataWe   (dataWe),
		.dataRdata(dataRdata),
		.wbValid  (wbValid),
		.wbRd     (wbRd),
		.wbData   (wbData)
	);

	// Both memories are word indexed and read combinationally.
	assign instrData = imem[instrAddr[9:2]];
	assign dataRdata = dmem[dataAddr[9:2]];

	always @(posedge clk) begin
		if (dataWe) begin
			dmem[dataAddr[9:2]] <= dataWdata;
		end
	end

	function automatic word fillWord(int idx);
		word addr;
		addr = word'(idx) << 2;
		return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
	endfunction

	function automatic instrWord rTypeInstr(logic [6:0] f7, regAddr rs2, regAddr rs1,
			logic [2:0] f3, regAddr rd);
		return {f7, rs2, rs1, f3, rd, opcodeOp};
	endfunction

	function automatic instrWord iTypeInstr(logic [11:0] imm, regAddr rs1, logic [2:0] f3,
			regAddr rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic instrWord sTypeInstr(logic [11:0] imm, regAddr rs2, regAddr rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opcodeStore};
	endfunction

	function automatic instrWord bTypeInstr(logic [12:0] imm, regAddr rs2, regAddr rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcodeBranch};
	endfunction

	function automatic instrWord jTypeInstr(logic [20:0] imm, regAddr rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcodeJal};
	endfunction

	// Small pool x0 to x4 keeps dependencies dense.
	function automatic regAddr pickReg();
		return regAddr'($urandom % 5);
	endfunction

	function automatic instrWord aluInstr(regAddr rd, regAddr rs1, regAddr rs2);
		int sel;
		sel = int'($urandom % 6);
		return rTypeInstr((sel == 1) ? 7'b0100000 : 7'b0000000, rs2, rs1, aluFunct3[sel], rd);
	endfunction

	`include "tbIsaModel.svh"

	// Branches and jumps only go forward, so every program reaches its final loop.
	task automatic makeProgram(output int len);
		int kind;
		int k;
		len = 40 + int'($urandom % 41);
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
		end
		for (int i = 0; i < len; i++) begin
			kind = int'($urandom % 10);
			k = 1 + int'($urandom % 3);
			if (i + k > len) begin
				k = len - i;
			end
			case (kind)
				0, 1, 2: imem[i] = aluInstr(pickReg(), pickReg(), pickReg());
				3, 4: imem[i] = iTypeInstr(12'($urandom), pickReg(), 3'b000, pickReg(),
					opcodeOpImm);
				5: imem[i] = iTypeInstr(12'(($urandom % 16) * 4), pickReg(), 3'b010, pickReg(),
					opcodeLoad);
				6: imem[i] = sTypeInstr(12'(($urandom % 16) * 4), pickReg(), pickReg());
				7: imem[i] = bTypeInstr(13'(k * 4), pickReg(), pickReg(), 3'b000);
				8: imem[i] = bTypeInstr(13'(k * 4), pickReg(), pickReg(), 3'b001);
				default: imem[i] = jTypeInstr(21'(k * 4), pickReg());
			endcase
		end
		imem[len] = jTypeInstr(21'd0, 5'd0);
	endtask

	task automatic checkReset();
		assert (!wbValid) else begin
			errorsOther++;
			$display("[ERROR] %s reset wbValid: expected 0 actual %b", testName, wbValid);
		end
		assert (!dataWe) else begin
			errorsOther++;
			$display("[ERROR] %s reset dataWe: expected 0 actual %b", testName, dataWe);
		end
		assert (instrAddr == resetVec) else begin
			errorsOther++;
			$display("[ERROR] %s reset instrAddr: expected %h actual %h",
				testName, resetVec, instrAddr);
		end
	endtask

	// Outputs are registered, so they are stable at the falling edge.
	always @(negedge clk) begin
		wbEvent expWb;
		storeEvent expSt;
		if (wbValid) begin
			assert (wbQ.size() > 0) else begin
				errorsOther++;
				$display("%s: writeback to x%0d when none was expected", testName, wbRd);
			end
			if (wbQ.size() > 0) begin
				expWb = wbQ.pop_front();
				assert (wbRd == expWb.rd && wbData == expWb.data) else begin
					errorsWb++;
					$display("[ERROR] %s writeback: expected x%0d=%h actual x%0d=%h",
						testName, expWb.rd, expWb.data, wbRd, wbData);
				end
			end
		end
		if (dataWe) begin
			assert (stQ.size() > 0) else begin
				errorsOther++;
				$display("%s: store to %h when none was expected", testName, dataAddr);
			end
			if (stQ.size() > 0) begin
				expSt = stQ.pop_front();
				assert (dataAddr == expSt.addr && dataWdata == expSt.data) else begin
					errorsStore++;
					$display("[ERROR] %s store: expected [%h]=%h actual [%h]=%h",
						testName, expSt.addr, expSt.data, dataAddr, dataWdata);
				end
			end
		end
	end

	initial begin
		int len;
		reset = 1'b1;
		void'($urandom(32'h2715_0da8));
		for (int t = 0; t < numPrograms; t++) begin
			testName = $sformatf("random%0d", t);
			reset = 1'b1;
			makeProgram(len);
			for (int i = 0; i < 256; i++) begin
				dmem[i] = fillWord(i);
			end
			runModel(4 * maxProgLen);
			repeat (8) begin
				@(negedge clk);
				checkReset();
			end
			reset = 1'b0;
			checkReset();
			while (wbQ.size() != 0 || stQ.size() != 0) begin
				@(negedge clk);
			end
			// Let the final loop spin to catch late or extra writebacks.
			repeat (12) @(negedge clk);
		end
		$display("Errors: %0d writeback, %0d store, %0d other",
			errorsWb, errorsStore, errorsOther);
		if (errorsWb + errorsStore + errorsOther == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		#(limitCycles * 8);
		$display("Timeout: the run did not finish within %0d cycles", limitCycles);
		$display("Verification failed");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+testbench
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/regFile.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/hazardUnit.sv
rtl/cpuCore.sv
testbench/cpuCoreTb.sv
